// File: src/rw_mem_pkg.sv
/*
 * Memory side definitions for the read/write generator
 * Address, data and counter widths, request command enum,
 * memory request packet and engine data word
 */
package rw_mem_pkg;

    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int COUNT_W = 16;

    // Request packet without its valid bit
    localparam int REQ_PAYLOAD_W = 1 + ADDR_W + DATA_W;

    typedef enum logic [0:0] {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } mem_cmd_e;

    typedef struct packed {
        logic              valid;
        mem_cmd_e          cmd;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] data;
    } mem_request_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } engine_data_t;

endpackage

// File: src/rw_engine_pkg.sv
/*
 * Engine side definitions for the read/write generator
 * Job opcode enum, job configuration packet,
 * control FSM states and FIFO sizing
 */
package rw_engine_pkg;

    // --------------------
    // FIFO sizing
    // --------------------
    localparam int FIFO_DEPTH  = 16;
    // Room for both kernel stages plus margin
    localparam int PROG_THRESH = 12;

    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } rw_opcode_e;

    typedef struct packed {
        logic                               valid;
        rw_opcode_e                         opcode;
        logic                               mode_counter;
        logic [rw_mem_pkg::ADDR_W-1:0]      index_start;
        logic [rw_mem_pkg::ADDR_W-1:0]      index_stride;
        logic [rw_mem_pkg::COUNT_W-1:0]     item_count;
    } rw_config_t;

    // --------------------
    // Job FSM
    // --------------------
    typedef enum logic [2:0] {
        RESET      = 3'd0,
        IDLE       = 3'd1,
        SETUP_REQ  = 3'd2,
        SETUP_WAIT = 3'd3,
        BUSY       = 3'd4,
        DRAIN      = 3'd5,
        DONE       = 3'd6
    } rw_state_e;

endpackage

// File: src/rw_sync_fifo.sv
/*
 * Synchronous register-array FIFO
 * Registered read data, empty, full and prog_full flags
 */
`timescale 1ns/10ps

module rw_sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = rw_engine_pkg::FIFO_DEPTH
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);
    import rw_engine_pkg::*;

    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;
    logic                     wr_en;
    logic                     rd_en;

    assign wr_en = push & ~full;
    assign rd_en = pop & ~empty;

    // Storage and read port
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
        if (rd_en) begin
            dout <= mem[rd_ptr];
        end
    end

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty     = (count == '0);
    assign full      = (count == DEPTH);
    assign prog_full = (count >= PROG_THRESH);

endmodule

// File: src/rw_gen_ingress.sv
/*
 * Input side of the generator
 * Engine data FIFO and gated pop toward the kernel
 */
`timescale 1ns/10ps

module rw_gen_ingress (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  rw_mem_pkg::engine_data_t data_in,
    input  logic                     accept,
    input  logic                     request_prog_full,
    output rw_mem_pkg::engine_data_t item,
    output logic                     input_empty
);
    import rw_mem_pkg::*;
    import rw_engine_pkg::*;

    logic [DATA_W-1:0] fifo_dout;
    logic              fifo_pop;
    logic              item_valid;

    // Hold off while the request FIFO backs up
    assign fifo_pop = accept & ~input_empty & ~request_prog_full;

    rw_sync_fifo #(
        .WIDTH(DATA_W),
        .DEPTH(FIFO_DEPTH)
    ) data_fifo_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (data_in.valid),
        .din             (data_in.data),
        .pop             (fifo_pop),
        .dout            (fifo_dout),
        .empty           (input_empty),
        .full            (),
        .prog_full       ()
    );

    // Word shows up one cycle after the pop
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            item_valid <= 1'b0;
        end else begin
            item_valid <= fifo_pop;
        end
    end

    assign item = '{valid: item_valid, data: fifo_dout};

endmodule

// File: src/rw_gen_control.sv
/*
 * Job control for the generator
 * FSM, configuration capture, item counting and done decision
 */
`timescale 1ns/10ps

module rw_gen_control (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      descriptor_valid,
    input  rw_engine_pkg::rw_config_t config_in,
    input  rw_mem_pkg::engine_data_t  item,
    input  logic                      kernel_busy,
    input  logic                      input_empty,
    input  logic                      request_empty,
    input  logic                      outstanding_zero,
    output logic                      config_request,
    output logic                      accept,
    output rw_engine_pkg::rw_config_t job,
    output logic                      job_start,
    output logic                      done
);
    import rw_mem_pkg::*;
    import rw_engine_pkg::*;

    rw_state_e            state;
    rw_state_e            next_state;
    logic [COUNT_W-1:0]   item_cnt;
    logic [COUNT_W:0]     items_taken;
    logic                 all_taken;
    logic                 capture;
    logic                 drained;

    // Count includes the word already popped and arriving now
    assign items_taken = {1'b0, item_cnt} + (COUNT_W + 1)'(item.valid);
    assign all_taken   = (items_taken >= {1'b0, job.item_count});
    assign capture     = (state == SETUP_WAIT) & config_in.valid;
    assign drained     = ~kernel_busy & input_empty & request_empty &
                         (outstanding_zero | ~job.mode_counter);

    // --------------------
    // Job FSM
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET:      next_state = IDLE;
            IDLE:       if (descriptor_valid) next_state = SETUP_REQ;
            SETUP_REQ:  next_state = SETUP_WAIT;
            SETUP_WAIT: if (config_in.valid) next_state = BUSY;
            BUSY:       if (all_taken) next_state = DRAIN;
            DRAIN:      if (drained) next_state = DONE;
            DONE:       if (descriptor_valid) next_state = SETUP_REQ;
            default:    next_state = RESET;
        endcase
    end

    // Configuration capture and item count
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            job       <= '0;
            job_start <= 1'b0;
            item_cnt  <= '0;
        end else begin
            job_start <= capture;
            if (capture) begin
                job      <= config_in;
                item_cnt <= '0;
            end else if (item.valid) begin
                item_cnt <= item_cnt + 1'b1;
            end
        end
    end

    assign config_request = (state == SETUP_REQ);
    assign accept         = (state == BUSY) & ~all_taken;
    assign done           = (state == DONE);

endmodule

// File: src/rw_gen_kernel.sv
/*
 * Two-stage request kernel
 * Stage one forms the address, stage two the command and data
 */
`timescale 1ns/10ps

module rw_gen_kernel (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  rw_engine_pkg::rw_config_t job,
    input  logic                      job_start,
    input  rw_mem_pkg::engine_data_t  item,
    output rw_mem_pkg::mem_request_t  kernel_request,
    output logic                      kernel_busy
);
    import rw_mem_pkg::*;
    import rw_engine_pkg::*;

    logic [ADDR_W-1:0] offset;
    logic              s1_valid;
    logic [ADDR_W-1:0] s1_addr;
    logic [DATA_W-1:0] s1_data;
    logic              s2_valid;
    mem_cmd_e          s2_cmd;
    logic [ADDR_W-1:0] s2_addr;
    logic [DATA_W-1:0] s2_data;

    // --------------------
    // Valid pipe and offset
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            offset   <= '0;
        end else begin
            s1_valid <= item.valid & job.valid;
            s2_valid <= s1_valid;
            if (job_start) begin
                offset <= '0;
            end else if (item.valid) begin
                offset <= offset + job.index_stride;
            end
        end
    end

    // Payload stages
    always_ff @(posedge ap_clk) begin
        s1_addr <= job.index_start + offset;
        s1_data <= item.data;
        s2_addr <= s1_addr;
        s2_cmd  <= (job.opcode == OP_WRITE) ? CMD_WRITE : CMD_READ;
        // Reads carry no data
        s2_data <= (job.opcode == OP_WRITE) ? s1_data : '0;
    end

    assign kernel_request = '{valid: s2_valid, cmd: s2_cmd, address: s2_addr, data: s2_data};
    assign kernel_busy    = s1_valid | s2_valid;

endmodule

// File: src/rw_gen_egress.sv
/*
 * Output side of the generator
 * Request FIFO, ready-driven pop and outstanding request counter
 */
`timescale 1ns/10ps

module rw_gen_egress (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  rw_mem_pkg::mem_request_t kernel_request,
    input  logic                     request_ready,
    input  logic                     memory_ack,
    output rw_mem_pkg::mem_request_t request_out,
    output logic                     request_prog_full,
    output logic                     request_empty,
    output logic                     outstanding_zero
);
    import rw_mem_pkg::*;
    import rw_engine_pkg::*;

    logic [REQ_PAYLOAD_W-1:0] fifo_din;
    logic [REQ_PAYLOAD_W-1:0] fifo_dout;
    logic                     fifo_pop;
    logic                     out_valid;
    logic [COUNT_W-1:0]       outstanding;

    assign fifo_din = {kernel_request.cmd, kernel_request.address, kernel_request.data};
    assign fifo_pop = request_ready & ~request_empty;

    rw_sync_fifo #(
        .WIDTH(REQ_PAYLOAD_W),
        .DEPTH(FIFO_DEPTH)
    ) request_fifo_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (kernel_request.valid),
        .din             (fifo_din),
        .pop             (fifo_pop),
        .dout            (fifo_dout),
        .empty           (request_empty),
        .full            (),
        .prog_full       (request_prog_full)
    );

    // --------------------
    // Issue and outstanding count
    // --------------------
    // Counted at the pop so the count is up before the FIFO reads empty
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_valid   <= 1'b0;
            outstanding <= '0;
        end else begin
            out_valid <= fifo_pop;
            case ({fifo_pop, memory_ack})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    assign request_out      = mem_request_t'({out_valid, fifo_dout});
    assign outstanding_zero = (outstanding == '0);

endmodule

// File: src/rw_gen_top.sv
/*
 * Read/write request generator top level
 * Input side, job control, kernel and output side
 */
`timescale 1ns/10ps

module rw_gen_top (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  logic                      descriptor_valid,
    output logic                      config_request,
    input  rw_engine_pkg::rw_config_t config_in,
    input  rw_mem_pkg::engine_data_t  data_in,
    output rw_mem_pkg::mem_request_t  request_out,
    input  logic                      request_ready,
    input  logic                      memory_ack,
    output logic                      done
);
    import rw_mem_pkg::*;
    import rw_engine_pkg::*;

    logic         accept;
    engine_data_t item;
    rw_config_t   job;
    logic         job_start;
    mem_request_t kernel_request;
    logic         kernel_busy;
    logic         input_empty;
    logic         request_empty;
    logic         request_prog_full;
    logic         outstanding_zero;

    rw_gen_ingress ingress_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .data_in          (data_in),
        .accept           (accept),
        .request_prog_full(request_prog_full),
        .item             (item),
        .input_empty      (input_empty)
    );

    rw_gen_control control_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .descriptor_valid(descriptor_valid),
        .config_in       (config_in),
        .item            (item),
        .kernel_busy     (kernel_busy),
        .input_empty     (input_empty),
        .request_empty   (request_empty),
        .outstanding_zero(outstanding_zero),
        .config_request  (config_request),
        .accept          (accept),
        .job             (job),
        .job_start       (job_start),
        .done            (done)
    );

    rw_gen_kernel kernel_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .job             (job),
        .job_start       (job_start),
        .item            (item),
        .kernel_request  (kernel_request),
        .kernel_busy     (kernel_busy)
    );

    rw_gen_egress egress_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .kernel_request   (kernel_request),
        .request_ready    (request_ready),
        .memory_ack       (memory_ack),
        .request_out      (request_out),
        .request_prog_full(request_prog_full),
        .request_empty    (request_empty),
        .outstanding_zero (outstanding_zero)
    );

endmodule

// File: verification/rw_gen_assert.sv
/*
 * Bound checks for the generator top level
 * FIFO overflow and underflow, config strobe width, done against accept
 */
`timescale 1ns/10ps

module rw_gen_assert (
    input logic ap_clk,
    input logic areset_generator,
    input logic config_request,
    input logic accept,
    input logic done,
    input logic in_push,
    input logic in_pop,
    input logic in_full,
    input logic req_push,
    input logic req_pop,
    input logic req_full
);

    // Number of failed assertions
    int unsigned fail_count = 0;

    // Words taken in and handed out by each FIFO since reset
    int unsigned in_pushes;
    int unsigned in_pops;
    int unsigned req_pushes;
    int unsigned req_pops;

    always @(posedge ap_clk) begin
        if (areset_generator) begin
            in_pushes  <= 0;
            in_pops    <= 0;
            req_pushes <= 0;
            req_pops   <= 0;
        end else begin
            in_pushes  <= in_pushes + (in_push && !in_full);
            in_pops    <= in_pops + in_pop;
            req_pushes <= req_pushes + (req_push && !req_full);
            req_pops   <= req_pops + req_pop;
        end
    end

    // --------------------
    // FIFO safety
    // --------------------
    input_no_overflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator) !(in_push && in_full)
    ) else begin
        $error("Input FIFO pushed while full");
        fail_count++;
    end

    // A pop needs a word that was pushed in an earlier cycle
    input_no_underflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator) in_pop |-> (in_pushes > in_pops)
    ) else begin
        $error("Input FIFO popped while empty");
        fail_count++;
    end

    request_no_overflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator) !(req_push && req_full)
    ) else begin
        $error("Request FIFO pushed while full");
        fail_count++;
    end

    request_no_underflow: assert property (
        @(posedge ap_clk) disable iff (areset_generator) req_pop |-> (req_pushes > req_pops)
    ) else begin
        $error("Request FIFO popped while empty");
        fail_count++;
    end

    // --------------------
    // Strobe rules
    // --------------------
    config_single_cycle: assert property (
        @(posedge ap_clk) disable iff (areset_generator) config_request |=> !config_request
    ) else begin
        $error("config_request held longer than one cycle");
        fail_count++;
    end

    done_excludes_accept: assert property (
        @(posedge ap_clk) disable iff (areset_generator) !(done && accept)
    ) else begin
        $error("done and accept high together");
        fail_count++;
    end

endmodule

bind rw_gen_top rw_gen_assert rw_gen_assert_i (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator),
    .config_request  (config_request),
    .accept          (accept),
    .done            (done),
    .in_push         (ingress_i.data_fifo_i.push),
    .in_pop          (ingress_i.data_fifo_i.pop),
    .in_full         (ingress_i.data_fifo_i.full),
    .req_push        (egress_i.request_fifo_i.push),
    .req_pop         (egress_i.request_fifo_i.pop),
    .req_full        (egress_i.request_fifo_i.full)
);

// File: verification/rw_gen_tb.sv
/*
 * Testbench for the read/write request generator
 * Vector reader, job stimulus, request scoreboard,
 * ready and ack models, cycle timeout and final report
 */
`timescale 1ns/10ps

module rw_gen_tb;
    import rw_mem_pkg::*;
    import rw_engine_pkg::*;

    // One job as read from the vector file
    typedef struct packed {
        logic               write;
        logic               mode_counter;
        logic               ready_random;
        logic [ADDR_W-1:0]  start;
        logic [ADDR_W-1:0]  stride;
        logic [COUNT_W-1:0] count;
        logic [15:0]        first;
    } job_vec_t;

    logic         ap_clk = 1'b0;
    logic         areset_generator = 1'b1;
    logic         descriptor_valid = 1'b0;
    logic         config_request;
    rw_config_t   config_in = '0;
    engine_data_t data_in = '0;
    mem_request_t request_out;
    logic         request_ready = 1'b0;
    logic         memory_ack = 1'b0;
    logic         done;

    job_vec_t          jobs [8];
    logic [DATA_W-1:0] words [64];
    mem_request_t      expected [64];
    mem_request_t      exp_q [$];
    int                num_jobs = 0;
    int                num_items = 0;
    int                errors = 0;
    int                tests_failed = 0;
    int                timeout_limit = 200;
    int                cycle_count = 0;
    int                reqs_seen = 0;
    int                acks_sent = 0;
    int                cfg_pulses = 0;
    int                ack_limit = 0;
    int                ack_wait = 0;
    int                ready_left = 0;
    logic              ready_random = 1'b0;

    rw_gen_top rw_gen_top_i (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .descriptor_valid(descriptor_valid),
        .config_request  (config_request),
        .config_in       (config_in),
        .data_in         (data_in),
        .request_out     (request_out),
        .request_ready   (request_ready),
        .memory_ack      (memory_ack),
        .done            (done)
    );

    always #2 ap_clk = ~ap_clk;

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors > errors_before) begin
            tests_failed++;
            $display("%s: FAIL (%0d errors)", name, errors - errors_before);
        end else begin
            $display("%s: pass", name);
        end
    endtask

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // --------------------
    // Scoreboard, ready and ack models
    // --------------------
    always @(negedge ap_clk) begin
        mem_request_t exp_req;
        if (!areset_generator) begin
            if (config_request) begin
                cfg_pulses <= cfg_pulses + 1;
            end
            if (request_out.valid) begin
                reqs_seen <= reqs_seen + 1;
                // A job is only done once its last request has gone out
                compare_value("done while a request is out", done, 0);
                if (exp_q.size() == 0) begin
                    $display("Unexpected request at %0d ns when none was due", $time);
                    errors++;
                end else begin
                    exp_req = exp_q.pop_front();
                    compare_value("cmd", request_out.cmd, exp_req.cmd);
                    compare_value("address", request_out.address, exp_req.address);
                    compare_value("data", request_out.data, exp_req.data);
                end
            end
        end
        // Long low stretches with short ready bursts
        if (!ready_random) begin
            request_ready = 1'b1;
        end else if (ready_left == 0) begin
            request_ready = ~request_ready;
            ready_left = request_ready ? 1 + $urandom % 4 : 8 + $urandom % 24;
        end else begin
            ready_left--;
        end
        // Acks follow issued requests with a short random delay
        memory_ack = 1'b0;
        if (acks_sent < ack_limit && acks_sent < reqs_seen) begin
            if (ack_wait == 0) begin
                memory_ack = 1'b1;
                acks_sent <= acks_sent + 1;
                ack_wait = $urandom % 4;
            end else begin
                ack_wait--;
            end
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int unsigned       seed;
        int                fd;
        int                op;
        int                mode;
        int                rnd;
        int                cnt;
        int                base;
        int                errors_before;
        int                assert_fails;
        string             line;
        job_vec_t          jv;
        logic [DATA_W-1:0] d;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] s;

        seed = $urandom(68061);
        base = 0;
        fd = $fopen("verification/rw_gen_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file verification/rw_gen_vectors.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) == "J") begin
                    void'($sscanf(line, "J %d %d %d %h %h %d", op, mode, rnd, a, s, cnt));
                    jobs[num_jobs] = '{write: op[0], mode_counter: mode[0],
                                       ready_random: rnd[0], start: a, stride: s,
                                       count: cnt[COUNT_W-1:0], first: num_items[15:0]};
                    num_jobs++;
                end else if (line.len() > 1 && line.getc(0) == "W") begin
                    void'($sscanf(line, "W %h %h %h", words[num_items], a, d));
                    expected[num_items] = '{valid: 1'b1,
                        cmd: jobs[num_jobs-1].write ? CMD_WRITE : CMD_READ,
                        address: a, data: d};
                    num_items++;
                end
            end
            $fclose(fd);
        end
        timeout_limit = num_items * 40 + 200;

        repeat (2) @(negedge ap_clk);
        areset_generator = 1'b0;
        @(negedge ap_clk);
        compare_value("done after reset", done, 0);
        compare_value("config_request after reset", config_request, 0);
        compare_value("request_out.valid after reset", request_out.valid, 0);
        report_test("reset", 0);

        for (int j = 0; j < num_jobs; j++) begin
            jv = jobs[j];
            errors_before = errors;
            ready_random <= jv.ready_random;
            ack_limit <= jv.mode_counter ? base + jv.count - 1 : base;
            descriptor_valid = 1'b1;
            @(negedge ap_clk);
            descriptor_valid = 1'b0;
            while (!config_request) @(negedge ap_clk);
            // Words go in ahead of the configuration and wait in the input FIFO
            for (int i = 0; i < jv.count; i++) begin
                @(negedge ap_clk);
                data_in = '{valid: 1'b1, data: words[jv.first + i]};
                exp_q.push_back(expected[jv.first + i]);
            end
            @(negedge ap_clk);
            data_in = '0;
            config_in = '{valid: 1'b1, opcode: jv.write ? OP_WRITE : OP_READ,
                          mode_counter: jv.mode_counter, index_start: jv.start,
                          index_stride: jv.stride, item_count: jv.count};
            @(negedge ap_clk);
            config_in = '0;
            while (reqs_seen < base + jv.count) @(negedge ap_clk);

            if (jv.mode_counter) begin
                // Last ack held back, done has to wait for it
                while (acks_sent < base + jv.count - 1) @(negedge ap_clk);
                repeat (6) begin
                    @(negedge ap_clk);
                    compare_value("done before last ack", done, 0);
                end
                ack_limit <= base + jv.count;
                while (!done) @(negedge ap_clk);
                compare_value("acks at done", acks_sent, base + jv.count);
            end else begin
                while (!done) @(negedge ap_clk);
                ack_limit <= base + jv.count;
                while (acks_sent < base + jv.count) @(negedge ap_clk);
            end
            compare_value("config_request pulses", cfg_pulses, j + 1);
            base += jv.count;
            report_test($sformatf("job %0d %s, %0d items", j, jv.write ? "write" : "read",
                                  jv.count), errors_before);
        end

        assert_fails = rw_gen_top_i.rw_gen_assert_i.fail_count;
        if (assert_fails != 0) begin
            $display("Bound assertions failed %0d times", assert_fails);
            errors += assert_fails;
        end

        $display("Tests run %0d, failed %0d, errors %0d", num_jobs + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verification/rw_gen_vectors.txt
# J write mode_counter ready_random index_start index_stride item_count
# W data_word expected_address expected_data
J 1 0 0 00001000 00000004 4
W a0000001 00001000 a0000001
W a0000002 00001004 a0000002
W a0000003 00001008 a0000003
W a0000004 0000100c a0000004
J 0 1 0 00020000 00000010 3
W 11111111 00020000 00000000
W 22222222 00020010 00000000
W 33333333 00020020 00000000
J 1 0 1 80000000 00000100 13
W c0de0000 80000000 c0de0000
W c0de0001 80000100 c0de0001
W c0de0002 80000200 c0de0002
W c0de0003 80000300 c0de0003
W c0de0004 80000400 c0de0004
W c0de0005 80000500 c0de0005
W c0de0006 80000600 c0de0006
W c0de0007 80000700 c0de0007
W c0de0008 80000800 c0de0008
W c0de0009 80000900 c0de0009
W c0de000a 80000a00 c0de000a
W c0de000b 80000b00 c0de000b
W c0de000c 80000c00 c0de000c
J 1 1 1 fffffff0 00000008 3
W 5a5a0001 fffffff0 5a5a0001
W 5a5a0002 fffffff8 5a5a0002
W 5a5a0003 00000000 5a5a0003

// File: tb.f
src/rw_mem_pkg.sv
src/rw_engine_pkg.sv
src/rw_sync_fifo.sv
src/rw_gen_ingress.sv
src/rw_gen_control.sv
src/rw_gen_kernel.sv
src/rw_gen_egress.sv
src/rw_gen_top.sv
verification/rw_gen_assert.sv
verification/rw_gen_tb.sv

// File: Bender.yml
package:
  name: rw_gen

sources:
  - files:
      - src/rw_mem_pkg.sv
      - src/rw_engine_pkg.sv
      - src/rw_sync_fifo.sv
      - src/rw_gen_ingress.sv
      - src/rw_gen_control.sv
      - src/rw_gen_kernel.sv
      - src/rw_gen_egress.sv
      - src/rw_gen_top.sv
  - target: test
    files:
      - verification/rw_gen_assert.sv
      - verification/rw_gen_tb.sv
